/* rtl/cpr_pkg.sv */
`default_nettype none

package cpr_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [22:0] rom_addr_t;
    typedef logic [15:0] boot_addr_t;      // Z80 address space
    typedef logic [31:0] fourcc_t;         // First received character on top
    typedef logic [31:0] chunk_len_t;
    typedef logic [4:0]  block_num_t;
    typedef logic [1:0]  cfg_addr_t;

    localparam byte_t   CPR_INDEX  = 8'd5;   // Download slot for CPR images
    localparam int      BLOCK_SIZE = 16384;
    localparam int      NUM_BLOCKS = 32;

    // Signatures as they appear in the byte stream
    localparam fourcc_t     SIG_RIFF  = "RIFF";
    localparam fourcc_t     SIG_AMS   = "AMS!";
    localparam fourcc_t     SIG_FMT   = "fmt ";
    localparam logic [23:0] CB_PREFIX = "cb0";

    typedef enum logic [2:0] {
        PS_RIFF,
        PS_RIFF_LEN,
        PS_FORM,
        PS_CHUNK_ID,
        PS_CHUNK_LEN,
        PS_PAYLOAD
    } parse_state_t;

    typedef enum logic [1:0] {
        CK_SKIP,
        CK_FMT,
        CK_BLOCK
    } chunk_kind_t;

    typedef struct packed {
        logic  download;
        logic  wr;
        byte_t index;
        byte_t data;
    } dl_stream_t;

    // One chunk payload byte with its position
    typedef struct packed {
        logic        strobe;
        chunk_kind_t kind;
        block_num_t  block;
        chunk_len_t  offset;
        byte_t       data;
    } payload_t;

    typedef struct packed {
        logic      wr;
        rom_addr_t addr;
        byte_t     data;
    } rom_write_t;

    typedef struct packed {
        logic      wr;
        cfg_addr_t addr;
        byte_t     data;
    } cfg_write_t;

    typedef struct packed {
        logic       strobe;
        boot_addr_t exec_addr;
    } boot_req_t;

endpackage

`default_nettype wire

/* rtl/riff_chunk_parser.sv */
`default_nettype none

module riff_chunk_parser (
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire cpr_pkg::dl_stream_t dl,
    output cpr_pkg::payload_t     payload
);

    logic                  accept;
    logic [1:0]            byte_cnt;   // Position within a four-byte field
    logic                  last_of_four;
    cpr_pkg::fourcc_t      shift_q;
    cpr_pkg::fourcc_t      id_next;
    cpr_pkg::chunk_len_t   len_next;
    cpr_pkg::chunk_len_t   remaining;
    cpr_pkg::chunk_len_t   offset;
    cpr_pkg::chunk_kind_t  id_kind;
    cpr_pkg::chunk_kind_t  cur_kind;
    cpr_pkg::block_num_t   id_block;
    cpr_pkg::block_num_t   cur_block;
    cpr_pkg::parse_state_t state;

    assign accept       = dl.download && dl.wr && (dl.index == cpr_pkg::CPR_INDEX);
    assign last_of_four = (byte_cnt == 2'd3);
    assign id_next      = {shift_q[23:0], dl.data};  // Characters shift in from the bottom
    assign len_next     = {dl.data, shift_q[31:8]};  // Little-endian, LSB first

    // Chunk id classification on the fourth id byte
    always_comb begin
        id_kind  = cpr_pkg::CK_SKIP;
        id_block = '0;
        if (id_next == cpr_pkg::SIG_FMT) begin
            id_kind = cpr_pkg::CK_FMT;
        end else if (id_next[31:8] == cpr_pkg::CB_PREFIX) begin
            if (dl.data >= "0" && dl.data <= "9") begin
                id_kind  = cpr_pkg::CK_BLOCK;
                id_block = cpr_pkg::block_num_t'(dl.data - "0");
            end else if (dl.data >= "A" && dl.data <= "V") begin
                id_kind  = cpr_pkg::CK_BLOCK;
                id_block = cpr_pkg::block_num_t'(dl.data - "A" + 8'd10);  // Blocks 10 to 31
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state          <= cpr_pkg::PS_RIFF;
            byte_cnt       <= '0;
            payload.strobe <= 1'b0;
        end else begin
            payload.strobe <= 1'b0;
            if (!dl.download) begin
                // Download ended, wait for the next image
                state    <= cpr_pkg::PS_RIFF;
                byte_cnt <= '0;
            end else if (accept) begin
                byte_cnt <= byte_cnt + 2'd1;
                case (state)
                    cpr_pkg::PS_RIFF: begin
                        shift_q <= id_next;
                        if (last_of_four && id_next == cpr_pkg::SIG_RIFF) begin
                            state <= cpr_pkg::PS_RIFF_LEN;
                        end
                    end
                    cpr_pkg::PS_RIFF_LEN: begin
                        shift_q <= len_next;  // File length is not needed
                        if (last_of_four) begin
                            state <= cpr_pkg::PS_FORM;
                        end
                    end
                    cpr_pkg::PS_FORM: begin
                        shift_q <= id_next;
                        if (last_of_four) begin
                            state <= (id_next == cpr_pkg::SIG_AMS) ? cpr_pkg::PS_CHUNK_ID
                                                                   : cpr_pkg::PS_RIFF;
                        end
                    end
                    cpr_pkg::PS_CHUNK_ID: begin
                        shift_q <= id_next;
                        if (last_of_four) begin
                            cur_kind  <= id_kind;
                            cur_block <= id_block;
                            state     <= cpr_pkg::PS_CHUNK_LEN;
                        end
                    end
                    cpr_pkg::PS_CHUNK_LEN: begin
                        shift_q <= len_next;
                        if (last_of_four) begin
                            remaining <= len_next;
                            offset    <= '0;
                            // Empty chunk has no payload
                            state     <= (len_next == '0) ? cpr_pkg::PS_CHUNK_ID
                                                          : cpr_pkg::PS_PAYLOAD;
                        end
                    end
                    cpr_pkg::PS_PAYLOAD: begin
                        byte_cnt       <= '0;
                        payload.strobe <= 1'b1;
                        payload.kind   <= cur_kind;
                        payload.block  <= cur_block;
                        payload.offset <= offset;
                        payload.data   <= dl.data;
                        offset         <= offset + 32'd1;
                        remaining      <= remaining - 32'd1;
                        if (remaining == 32'd1) begin
                            state <= cpr_pkg::PS_CHUNK_ID;
                        end
                    end
                    default: state <= cpr_pkg::PS_RIFF;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cart_block_writer.sv */
`default_nettype none

module cart_block_writer (
    input  wire                    clk_sys,
    input  wire                    reset,
    input  wire cpr_pkg::payload_t payload,
    output cpr_pkg::rom_write_t    rom
);

    logic                in_block;
    logic                block_byte;
    cpr_pkg::rom_addr_t  wr_addr;

    // Only the first 16 KB of a block reach the ROM
    assign in_block   = payload.offset < cpr_pkg::chunk_len_t'(cpr_pkg::BLOCK_SIZE);
    assign block_byte = payload.strobe && (payload.kind == cpr_pkg::CK_BLOCK);

    // Block base plus offset into the block
    assign wr_addr = cpr_pkg::rom_addr_t'(payload.block * cpr_pkg::BLOCK_SIZE
                                          + payload.offset);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rom.wr <= 1'b0;
        end else begin
            rom.wr   <= block_byte && in_block;  // One pulse per stored byte
            rom.addr <= wr_addr;
            rom.data <= payload.data;
        end
    end

endmodule

`default_nettype wire

/* rtl/fmt_chunk_decoder.sv */
`default_nettype none

module fmt_chunk_decoder (
    input  wire                    clk_sys,
    input  wire                    reset,
    input  wire cpr_pkg::payload_t payload,
    output cpr_pkg::byte_t         bios_version,
    output cpr_pkg::boot_addr_t    load_addr,
    output cpr_pkg::boot_req_t     boot_req
);

    logic                fmt_byte;
    cpr_pkg::byte_t      load_lo;   // Held until the high byte arrives
    cpr_pkg::byte_t      exec_lo;
    cpr_pkg::boot_addr_t exec_addr;

    assign fmt_byte  = payload.strobe && (payload.kind == cpr_pkg::CK_FMT);
    assign exec_addr = {payload.data, exec_lo};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            bios_version    <= '0;
            load_addr       <= '0;
            boot_req.strobe <= 1'b0;
        end else begin
            boot_req.strobe <= 1'b0;
            if (fmt_byte) begin
                case (payload.offset)
                    32'd0: bios_version <= payload.data;
                    32'd2: load_lo      <= payload.data;  // Offset 1 holds flags
                    32'd3: load_addr    <= {payload.data, load_lo};
                    32'd4: exec_lo      <= payload.data;
                    32'd5: begin
                        // Zero execution address means no auto-boot
                        boot_req.strobe    <= (exec_addr != '0);
                        boot_req.exec_addr <= exec_addr;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/boot_regs.sv */
`default_nettype none

module boot_regs (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  wire cpr_pkg::boot_req_t boot_req,
    input  wire cpr_pkg::cfg_write_t cfg,
    output cpr_pkg::byte_t          cart_bank,
    output logic                    auto_boot,
    output cpr_pkg::boot_addr_t     boot_addr,
    output logic                    bios_valid
);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cart_bank  <= '0;
            auto_boot  <= 1'b0;
            boot_addr  <= '0;
            bios_valid <= 1'b0;
        end else begin
            // Execution address found in the image
            if (boot_req.strobe) begin
                auto_boot  <= 1'b1;
                boot_addr  <= boot_req.exec_addr;
                bios_valid <= 1'b1;
            end

            // Host access comes last so it overrides the field it writes
            if (cfg.wr) begin
                case (cfg.addr)
                    2'd0: cart_bank       <= cfg.data;
                    2'd1: auto_boot       <= cfg.data[0];
                    2'd2: boot_addr[7:0]  <= cfg.data;   // Vector low byte
                    2'd3: boot_addr[15:8] <= cfg.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cpr_loader.sv */
`default_nettype none

module cpr_loader (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  wire cpr_pkg::dl_stream_t dl,
    input  wire cpr_pkg::cfg_write_t cfg,
    output cpr_pkg::rom_write_t      rom,
    output cpr_pkg::byte_t           cart_bank,
    output logic                     auto_boot,
    output cpr_pkg::boot_addr_t      boot_addr,
    output logic                     bios_valid,
    output cpr_pkg::byte_t           bios_version,
    output cpr_pkg::boot_addr_t      load_addr
);

    cpr_pkg::payload_t  payload;   // Tagged chunk bytes from the parser
    cpr_pkg::boot_req_t boot_req;

    riff_chunk_parser parser0 (
        .clk_sys (clk_sys),
        .reset   (reset),
        .dl      (dl),
        .payload (payload)
    );

    cart_block_writer writer0 (
        .clk_sys (clk_sys),
        .reset   (reset),
        .payload (payload),
        .rom     (rom)
    );

    fmt_chunk_decoder fmt0 (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .payload      (payload),
        .bios_version (bios_version),
        .load_addr    (load_addr),
        .boot_req     (boot_req)
    );

    boot_regs regs0 (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .boot_req   (boot_req),
        .cfg        (cfg),
        .cart_bank  (cart_bank),
        .auto_boot  (auto_boot),
        .boot_addr  (boot_addr),
        .bios_valid (bios_valid)
    );

endmodule

`default_nettype wire

/* verification/cpr_loader_checker.sv */
`default_nettype none

module cpr_loader_checker (
    input wire                      clk_sys,
    input wire                      reset,
    input wire cpr_pkg::dl_stream_t dl,
    input wire cpr_pkg::rom_write_t rom,
    input wire                      auto_boot,
    input wire                      bios_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Number of failed assertions

    // Every stored byte comes from a download two cycles back
    rom_wr_needs_download: assert property (
        @(posedge clk_sys) disable iff (reset)
        rom.wr |-> $past(dl.download, 2)
    ) else begin
        fail_count++;
        $error("ROM write without an active download two cycles earlier");
    end

    rom_addr_in_range: assert property (
        @(posedge clk_sys) disable iff (reset)
        rom.wr |-> (rom.addr < cpr_pkg::NUM_BLOCKS * cpr_pkg::BLOCK_SIZE)
    ) else begin
        fail_count++;
        $error("ROM write address %h beyond the last block", rom.addr);
    end

    boot_low_after_reset: assert property (
        @(posedge clk_sys)
        reset |=> (!auto_boot && !bios_valid)
    ) else begin
        fail_count++;
        $error("auto_boot or bios_valid high right after reset");
    end

endmodule

bind cpr_loader cpr_loader_checker chk0 (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .dl         (dl),
    .rom        (rom),
    .auto_boot  (auto_boot),
    .bios_valid (bios_valid)
);

`default_nettype wire

/* verification/tb_cpr_loader.sv */
`default_nettype none

module tb_cpr_loader;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [1:0]       img;
        cpr_pkg::fourcc_t id;
        logic [15:0]      len;
        logic [1:0]       pat;   // Payload pattern selector
    } chunk_row_t;

    localparam logic [1:0] PAT_RAND   = 2'd0;
    localparam logic [1:0] PAT_BOOT   = 2'd1;  // fmt chunk with an execution address
    localparam logic [1:0] PAT_NOBOOT = 2'd2;
    localparam int         NUM_ROWS   = 11;

    localparam chunk_row_t ROWS [NUM_ROWS] = '{
        '{2'd0, "cb00", 16'd20, PAT_RAND},
        '{2'd0, "DATA", 16'd10, PAT_RAND},     // Unknown chunk
        '{2'd0, "cb03", 16'd0, PAT_RAND},      // Empty block
        '{2'd0, "cb01", 16'd16400, PAT_RAND},  // Oversized block
        '{2'd0, "cb05", 16'd16, PAT_RAND},
        '{2'd0, "fmt ", 16'd16, PAT_BOOT},
        '{2'd0, "cb0V", 16'd12, PAT_RAND},
        '{2'd1, "cb00", 16'd8, PAT_RAND},
        '{2'd2, "cb02", 16'd8, PAT_RAND},
        '{2'd3, "fmt ", 16'd6, PAT_NOBOOT},
        '{2'd3, "cb02", 16'd5, PAT_RAND}
    };
    // Image 1 has a bad form type and image 2 goes to another download slot
    localparam cpr_pkg::fourcc_t IMG_FORM [4] = '{cpr_pkg::SIG_AMS, "AMS?",
                                                  cpr_pkg::SIG_AMS, cpr_pkg::SIG_AMS};
    localparam cpr_pkg::byte_t IMG_INDEX [4] = '{cpr_pkg::CPR_INDEX, cpr_pkg::CPR_INDEX,
                                                 8'd4, cpr_pkg::CPR_INDEX};

    logic                  clk_sys;
    logic                  reset;
    cpr_pkg::dl_stream_t   dl;
    cpr_pkg::cfg_write_t   cfg;
    cpr_pkg::rom_write_t   rom;
    cpr_pkg::byte_t        cart_bank;
    cpr_pkg::byte_t        bios_version;
    logic                  auto_boot;
    logic                  bios_valid;
    cpr_pkg::boot_addr_t   boot_addr;
    cpr_pkg::boot_addr_t   load_addr;

    cpr_pkg::byte_t        stream[$];
    cpr_pkg::rom_write_t   exp_q[$];   // ROM writes still to come
    cpr_pkg::byte_t        exp_version;
    cpr_pkg::boot_addr_t   exp_load;
    cpr_pkg::boot_addr_t   exp_exec;
    int                    cycles = 0;
    int                    cycle_limit;
    int unsigned           seed_dummy;

    cpr_loader dut0 (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .dl           (dl),
        .cfg          (cfg),
        .rom          (rom),
        .cart_bank    (cart_bank),
        .auto_boot    (auto_boot),
        .boot_addr    (boot_addr),
        .bios_valid   (bios_valid),
        .bios_version (bios_version),
        .load_addr    (load_addr)
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rom_write(input cpr_pkg::rom_write_t got,
                                   input cpr_pkg::rom_write_t exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: rom got %h/%h expected %h/%h",
                                     $time, got.addr, got.data, exp.addr, exp.data));
    endtask

    task automatic check_byte(input string name, input cpr_pkg::byte_t got,
                              input cpr_pkg::byte_t exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_boot(input string name, input cpr_pkg::boot_addr_t got,
                              input cpr_pkg::boot_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
    endtask

    // Block number of a "cb0x" id or -1 for other chunks
    function automatic int block_of(input cpr_pkg::fourcc_t id);
        cpr_pkg::byte_t c;
        c = id[7:0];
        if (id[31:8] != cpr_pkg::CB_PREFIX) return -1;
        if (c >= "0" && c <= "9") return c - "0";
        if (c >= "A" && c <= "V") return c - "A" + 10;
        return -1;
    endfunction

    function automatic cpr_pkg::byte_t fmt_byte(input int offset);
        case (offset)
            0: return exp_version;
            1: return 8'h00;           // Flags
            2: return exp_load[7:0];
            3: return exp_load[15:8];
            4: return exp_exec[7:0];
            5: return exp_exec[15:8];
            default: return cpr_pkg::byte_t'($urandom);
        endcase
    endfunction

    function automatic int total_stream_len();
        int total;
        total = 4 * 12;   // RIFF, file length and form of each image
        for (int r = 0; r < NUM_ROWS; r++) total += 8 + ROWS[r].len;
        return total;
    endfunction

    task automatic push_word(input logic [31:0] word, input bit big);
        for (int i = 0; i < 4; i++)
            stream.push_back(big ? word[31 - 8 * i -: 8] : word[8 * i +: 8]);
    endtask

    // Builds the byte stream of one image and queues the expected ROM writes
    task automatic build_image(input int img);
        int                  blk;
        int                  riff_len;
        bit                  valid;
        cpr_pkg::byte_t      b;
        cpr_pkg::rom_write_t w;
        stream.delete();
        riff_len = 4;
        for (int r = 0; r < NUM_ROWS; r++)
            if (ROWS[r].img == img) riff_len += 8 + ROWS[r].len;
        push_word(cpr_pkg::SIG_RIFF, 1'b1);
        push_word(riff_len, 1'b0);
        push_word(IMG_FORM[img], 1'b1);
        valid = (IMG_FORM[img] == cpr_pkg::SIG_AMS) && (IMG_INDEX[img] == cpr_pkg::CPR_INDEX);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ROWS[r].img != img) continue;
            if (ROWS[r].pat == PAT_BOOT) begin
                exp_version = 8'h21;
                exp_load    = 16'h8000;
                exp_exec    = 16'h0155;
            end else if (ROWS[r].pat == PAT_NOBOOT) begin
                exp_version = 8'h07;
                exp_load    = 16'h4000;
                exp_exec    = 16'h0000;
            end
            push_word(ROWS[r].id, 1'b1);
            push_word(ROWS[r].len, 1'b0);
            blk = block_of(ROWS[r].id);
            for (int i = 0; i < ROWS[r].len; i++) begin
                b = (ROWS[r].pat == PAT_RAND) ? cpr_pkg::byte_t'($urandom) : fmt_byte(i);
                stream.push_back(b);
                if (valid && blk >= 0 && i < cpr_pkg::BLOCK_SIZE) begin
                    w.wr   = 1'b1;
                    w.addr = cpr_pkg::rom_addr_t'(blk * cpr_pkg::BLOCK_SIZE + i);
                    w.data = b;
                    exp_q.push_back(w);
                end
            end
        end
    endtask

    task automatic run_image(input int img);
        build_image(img);
        @(negedge clk_sys);
        dl.download = 1'b1;
        dl.index    = IMG_INDEX[img];
        foreach (stream[i]) begin
            @(negedge clk_sys);
            if ($urandom_range(0, 3) == 0) begin
                dl.wr = 1'b0;   // Idle gap
                @(negedge clk_sys);
            end
            dl.wr   = 1'b1;
            dl.data = stream[i];
        end
        @(negedge clk_sys);
        dl.wr = 1'b0;
        while (exp_q.size() != 0) @(negedge clk_sys);
        repeat (3) @(negedge clk_sys);  // Boot register latency
        dl.download = 1'b0;
        @(negedge clk_sys);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(negedge clk_sys);
        reset = 1'b0;
    endtask

    task automatic host_write(input cpr_pkg::cfg_addr_t addr, input cpr_pkg::byte_t data);
        @(negedge clk_sys);
        cfg.wr   = 1'b1;
        cfg.addr = addr;
        cfg.data = data;
        @(negedge clk_sys);
        cfg.wr = 1'b0;
    endtask

    // ROM write monitor and run limit
    always @(posedge clk_sys) begin
        cycles++;
        if (cycles > cycle_limit)
            report_failure($sformatf("Timeout after %0d cycles", cycles));
        if (dut0.chk0.fail_count != 0)
            report_failure("An assertion in the bound checker failed");
        if (!reset && rom.wr === 1'b1) begin
            if (exp_q.size() == 0)
                report_failure($sformatf("Unexpected ROM write to address %h", rom.addr));
            else
                check_rom_write(rom, exp_q.pop_front());
        end
    end

    initial begin
        seed_dummy  = $urandom(96720);
        dl          = '0;
        cfg         = '0;
        reset       = 1'b1;
        cycle_limit = 2 * total_stream_len() + 100;
        apply_reset();

        run_image(0);
        check_byte("bios_version", bios_version, exp_version);
        check_boot("load_addr", load_addr, exp_load);
        check_flag("auto_boot", auto_boot, 1'b1);
        check_flag("bios_valid", bios_valid, 1'b1);
        check_boot("boot_addr", boot_addr, exp_exec);

        run_image(1);
        run_image(2);
        apply_reset();
        run_image(3);
        check_byte("bios_version", bios_version, exp_version);
        check_boot("load_addr", load_addr, exp_load);
        check_flag("auto_boot", auto_boot, 1'b0);
        check_flag("bios_valid", bios_valid, 1'b0);
        check_boot("boot_addr", boot_addr, 16'h0000);

        host_write(2'd0, 8'h5a);
        check_byte("cart_bank", cart_bank, 8'h5a);
        host_write(2'd1, 8'h01);
        check_flag("auto_boot", auto_boot, 1'b1);
        host_write(2'd2, 8'h34);
        host_write(2'd3, 8'h12);
        check_boot("boot_addr", boot_addr, 16'h1234);
        host_write(2'd1, 8'h00);
        check_flag("auto_boot", auto_boot, 1'b0);

        if (exp_q.size() == 0 && dut0.chk0.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_failure($sformatf("%0d expected ROM writes missing, %0d assertions failed",
                                     exp_q.size(), dut0.chk0.fail_count));
        end
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/cpr_pkg.sv
rtl/riff_chunk_parser.sv
rtl/cart_block_writer.sv
rtl/fmt_chunk_decoder.sv
rtl/boot_regs.sv
rtl/cpr_loader.sv
verification/cpr_loader_checker.sv
verification/tb_cpr_loader.sv
